//--- rtl/lock_pkg.sv
`default_nettype none

package lock_pkg;

    // decoded key, digits carry their own value
    typedef enum logic [3:0] {
        KEY_0      = 4'd0,
        KEY_1      = 4'd1,
        KEY_2      = 4'd2,
        KEY_3      = 4'd3,
        KEY_4      = 4'd4,
        KEY_5      = 4'd5,
        KEY_6      = 4'd6,
        KEY_7      = 4'd7,
        KEY_8      = 4'd8,
        KEY_9      = 4'd9,
        KEY_ENTER  = 4'd10,
        KEY_SET    = 4'd11,
        KEY_CLEAR  = 4'd12,  // clear entry and tries, relock when open
        KEY_CANCEL = 4'd13   // clear entry only
    } key_code_t;

    typedef struct packed {
        logic      valid;  // one cycle per press
        key_code_t key;
    } key_event_t;

    typedef enum logic [1:0] {
        ST_ENTRY   = 2'd0,
        ST_OPEN    = 2'd1,
        ST_SET     = 2'd2,
        ST_LOCKOUT = 2'd3
    } lock_state_t;

    typedef logic [3:0] glyph_t;  // 0..9 are digits

    localparam glyph_t GLYPH_A     = 4'hb;
    localparam glyph_t GLYPH_S     = 4'hc;
    localparam glyph_t GLYPH_DASH  = 4'hd;
    localparam glyph_t GLYPH_BLANK = 4'hf;

    typedef struct packed {
        glyph_t hi;
        glyph_t mid;
        glyph_t lo;
    } display_t;

endpackage

`default_nettype wire

//--- rtl/tone_pkg.sv
`default_nettype none

package tone_pkg;

    // buzzer patterns
    typedef enum logic [1:0] {
        TONE_CLICK   = 2'd0,  // short key click
        TONE_SUCCESS = 2'd1,  // long high tone
        TONE_FAIL    = 2'd2   // low double beep
    } tone_kind_t;

    // taken when valid and tone_ready are both high
    typedef struct packed {
        logic       valid;
        tone_kind_t kind;
    } tone_req_t;

endpackage

`default_nettype wire

//--- rtl/keypad_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          keys,
    output lock_pkg::key_event_t key_event
);

    logic [15:0]          prev_keys;  // pattern seen on the last edge
    logic                 key_hit;
    lock_pkg::key_code_t  key_code;

    // only exact one-hot patterns of wired keys count
    always_comb begin
        key_hit  = 1'b1;
        key_code = lock_pkg::KEY_ENTER;
        case (keys)
            16'h0001: key_code = lock_pkg::KEY_ENTER;
            16'h0008: key_code = lock_pkg::KEY_0;
            16'h0010: key_code = lock_pkg::KEY_SET;
            16'h0020: key_code = lock_pkg::KEY_3;
            16'h0040: key_code = lock_pkg::KEY_2;
            16'h0080: key_code = lock_pkg::KEY_1;
            16'h0100: key_code = lock_pkg::KEY_CLEAR;
            16'h0200: key_code = lock_pkg::KEY_6;
            16'h0400: key_code = lock_pkg::KEY_5;
            16'h0800: key_code = lock_pkg::KEY_4;
            16'h1000: key_code = lock_pkg::KEY_CANCEL;
            16'h2000: key_code = lock_pkg::KEY_9;
            16'h8000: key_code = lock_pkg::KEY_7;
            default:  key_hit  = 1'b0;  // unused lines, release, multi-key
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_keys       <= '0;
            key_event.valid <= 1'b0;
        end else begin
            prev_keys       <= keys;
            key_event.valid <= key_hit && (keys != prev_keys);  // held key gives no repeat
        end
        key_event.key <= key_code;
    end

endmodule

`default_nettype wire

//--- rtl/lock_controller.sv
`timescale 1ns/10ps
`default_nettype none

module lock_controller #(
    parameter int unsigned SECOND_CYCLES   = 50_000_000,
    parameter int unsigned MAX_TRIES       = 3,
    parameter int unsigned LOCKOUT_SECONDS = 20,
    parameter logic [11:0] DEFAULT_CODE    = 12'h246
) (
    input  logic                  clk,
    input  logic                  rst,
    input  lock_pkg::key_event_t  key_event,
    input  logic                  tone_ready,
    output tone_pkg::tone_req_t   tone_req,
    output lock_pkg::display_t    display,
    output lock_pkg::lock_state_t status,
    output logic [2:0]            tries
);

    localparam int SEC_W = $clog2(SECOND_CYCLES + 1);

    localparam lock_pkg::display_t BLANK_DISP = '{lock_pkg::GLYPH_BLANK,
        lock_pkg::GLYPH_BLANK, lock_pkg::GLYPH_BLANK};
    localparam lock_pkg::display_t DASH_DISP = '{lock_pkg::GLYPH_DASH,
        lock_pkg::GLYPH_DASH, lock_pkg::GLYPH_DASH};
    localparam lock_pkg::display_t PASS_DISP = '{lock_pkg::GLYPH_A,
        lock_pkg::GLYPH_S, lock_pkg::GLYPH_S};
    // countdown start in BCD, hundreds left blank
    localparam lock_pkg::display_t LOCK_DISP = '{lock_pkg::GLYPH_BLANK,
        4'(LOCKOUT_SECONDS / 10), 4'(LOCKOUT_SECONDS % 10)};

    logic [SEC_W-1:0]   sec_cnt;
    logic [1:0]         digit_cnt;  // digits entered so far
    lock_pkg::display_t code;       // stored code
    logic               key_digit;
    logic               sec_tick;
    logic [2:0]         tries_inc;

    assign key_digit = key_event.valid && (key_event.key <= lock_pkg::KEY_9);
    assign sec_tick  = (sec_cnt == SEC_W'(SECOND_CYCLES - 1));
    assign tries_inc = tries + 3'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            status    <= lock_pkg::ST_ENTRY;
            display   <= BLANK_DISP;
            tries     <= '0;
            digit_cnt <= '0;
            sec_cnt   <= '0;
            code      <= DEFAULT_CODE;
            tone_req  <= '0;
        end else begin
            if (tone_req.valid && tone_ready)
                tone_req.valid <= 1'b0;  // buzzer took it
            case (status)
                lock_pkg::ST_ENTRY, lock_pkg::ST_SET: begin
                    if (key_digit && digit_cnt != 2'd3) begin
                        display   <= '{display.mid, display.lo,
                                       lock_pkg::glyph_t'(key_event.key)};
                        digit_cnt <= digit_cnt + 2'd1;
                        tone_req  <= '{1'b1, tone_pkg::TONE_CLICK};
                    end else if (key_event.valid) begin
                        case (key_event.key)
                            lock_pkg::KEY_ENTER: begin
                                if (digit_cnt == 2'd3) begin
                                    digit_cnt <= '0;
                                    if (status == lock_pkg::ST_SET) begin
                                        code     <= display;  // new code
                                        status   <= lock_pkg::ST_ENTRY;
                                        display  <= BLANK_DISP;
                                        tone_req <= '{1'b1, tone_pkg::TONE_SUCCESS};
                                    end else if (display == code) begin
                                        status   <= lock_pkg::ST_OPEN;
                                        display  <= PASS_DISP;
                                        tone_req <= '{1'b1, tone_pkg::TONE_SUCCESS};
                                    end else begin
                                        tries    <= tries_inc;
                                        tone_req <= '{1'b1, tone_pkg::TONE_FAIL};
                                        if (tries_inc == 3'(MAX_TRIES)) begin
                                            status  <= lock_pkg::ST_LOCKOUT;
                                            display <= LOCK_DISP;
                                            sec_cnt <= '0;
                                        end else begin
                                            display <= BLANK_DISP;
                                        end
                                    end
                                end
                            end
                            lock_pkg::KEY_CANCEL: begin
                                display   <= BLANK_DISP;
                                digit_cnt <= '0;
                            end
                            lock_pkg::KEY_CLEAR: begin
                                display   <= BLANK_DISP;
                                digit_cnt <= '0;
                                status    <= lock_pkg::ST_ENTRY;  // relock from set
                                if (status == lock_pkg::ST_ENTRY)
                                    tries <= '0;
                            end
                            default: ;  // fourth digit, set
                        endcase
                    end
                end
                lock_pkg::ST_OPEN: begin
                    if (key_event.valid && key_event.key == lock_pkg::KEY_SET) begin
                        status    <= lock_pkg::ST_SET;
                        display   <= DASH_DISP;
                        digit_cnt <= '0;
                    end else if (key_event.valid && key_event.key == lock_pkg::KEY_CLEAR) begin
                        status    <= lock_pkg::ST_ENTRY;
                        display   <= BLANK_DISP;
                        digit_cnt <= '0;
                    end
                end
                lock_pkg::ST_LOCKOUT: begin  // keys ignored here
                    if (sec_tick) begin
                        sec_cnt <= '0;
                        if (display.mid == 4'd0 && display.lo == 4'd0) begin
                            status  <= lock_pkg::ST_ENTRY;
                            display <= BLANK_DISP;
                            tries   <= '0;
                        end else if (display.lo == 4'd0) begin
                            display.mid <= display.mid - 4'd1;  // BCD borrow
                            display.lo  <= 4'd9;
                        end else begin
                            display.lo <= display.lo - 4'd1;
                        end
                    end else begin
                        sec_cnt <= sec_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/buzzer_driver.sv
`timescale 1ns/10ps
`default_nettype none

module buzzer_driver #(
    parameter int unsigned CLICK_HALF   = 50_000,
    parameter int unsigned CLICK_LEN    = 10_000_000,
    parameter int unsigned SUCCESS_HALF = 25_000,
    parameter int unsigned SUCCESS_LEN  = 30_000_000,
    parameter int unsigned FAIL_HALF    = 100_000,
    parameter int unsigned FAIL_LEN     = 15_000_000
) (
    input  logic                clk,
    input  logic                rst,
    input  tone_pkg::tone_req_t tone_req,
    output logic                tone_ready,
    output logic                buzzer
);

    localparam int unsigned LEN_MAX  = (CLICK_LEN > SUCCESS_LEN) ?
        ((CLICK_LEN > FAIL_LEN) ? CLICK_LEN : FAIL_LEN) :
        ((SUCCESS_LEN > FAIL_LEN) ? SUCCESS_LEN : FAIL_LEN);
    localparam int unsigned HALF_MAX = (CLICK_HALF > SUCCESS_HALF) ?
        ((CLICK_HALF > FAIL_HALF) ? CLICK_HALF : FAIL_HALF) :
        ((SUCCESS_HALF > FAIL_HALF) ? SUCCESS_HALF : FAIL_HALF);
    localparam int LEN_W  = $clog2(LEN_MAX + 1);
    localparam int HALF_W = $clog2(HALF_MAX + 1);

    logic                 busy;
    logic                 phase;     // square wave level
    logic                 accept;
    logic                 gap;       // silent middle third of fail
    tone_pkg::tone_kind_t kind;
    logic [LEN_W-1:0]     len_cnt;
    logic [LEN_W-1:0]     len_lim;
    logic [HALF_W-1:0]    half_cnt;
    logic [HALF_W-1:0]    half_lim;

    assign tone_ready = !busy;
    assign accept     = tone_req.valid && tone_ready;
    assign gap        = (kind == tone_pkg::TONE_FAIL) && (len_cnt >= LEN_W'(FAIL_LEN / 3))
                        && (len_cnt < LEN_W'(2 * FAIL_LEN / 3));
    assign buzzer     = busy && phase && !gap;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            phase <= 1'b0;
        end else if (accept) begin
            busy  <= 1'b1;
            phase <= 1'b1;  // rises on the next cycle
        end else if (busy) begin
            if (len_cnt == len_lim - 1'b1)
                busy <= 1'b0;
            if (half_cnt == half_lim - 1'b1)
                phase <= !phase;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind     <= tone_req.kind;
            len_cnt  <= '0;
            half_cnt <= '0;
            case (tone_req.kind)
                tone_pkg::TONE_CLICK: begin
                    len_lim  <= LEN_W'(CLICK_LEN);
                    half_lim <= HALF_W'(CLICK_HALF);
                end
                tone_pkg::TONE_SUCCESS: begin
                    len_lim  <= LEN_W'(SUCCESS_LEN);
                    half_lim <= HALF_W'(SUCCESS_HALF);
                end
                default: begin
                    len_lim  <= LEN_W'(FAIL_LEN);
                    half_lim <= HALF_W'(FAIL_HALF);
                end
            endcase
        end else begin
            len_cnt  <= len_cnt + 1'b1;
            half_cnt <= (half_cnt == half_lim - 1'b1) ? '0 : half_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/code_lock_top.sv
`timescale 1ns/10ps
`default_nettype none

module code_lock_top #(
    parameter int unsigned SECOND_CYCLES   = 50_000_000,  // 1 s at 50 MHz
    parameter int unsigned MAX_TRIES       = 3,
    parameter int unsigned LOCKOUT_SECONDS = 20,
    parameter logic [11:0] DEFAULT_CODE    = 12'h246,
    parameter int unsigned CLICK_HALF      = 50_000,      // 500 Hz
    parameter int unsigned CLICK_LEN       = 10_000_000,
    parameter int unsigned SUCCESS_HALF    = 25_000,      // 1 kHz
    parameter int unsigned SUCCESS_LEN     = 30_000_000,
    parameter int unsigned FAIL_HALF       = 100_000,     // 250 Hz
    parameter int unsigned FAIL_LEN        = 15_000_000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           keys,
    output lock_pkg::display_t    display,
    output lock_pkg::lock_state_t status,
    output logic [2:0]            tries,
    output logic                  buzzer
);

    lock_pkg::key_event_t key_event;
    tone_pkg::tone_req_t  tone_req;
    logic                 tone_ready;

    keypad_decoder u_keypad_decoder (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_event (key_event)
    );

    lock_controller #(
        .SECOND_CYCLES   (SECOND_CYCLES),
        .MAX_TRIES       (MAX_TRIES),
        .LOCKOUT_SECONDS (LOCKOUT_SECONDS),
        .DEFAULT_CODE    (DEFAULT_CODE)
    ) u_lock_controller (
        .clk        (clk),
        .rst        (rst),
        .key_event  (key_event),
        .tone_ready (tone_ready),
        .tone_req   (tone_req),
        .display    (display),
        .status     (status),
        .tries      (tries)
    );

    buzzer_driver #(
        .CLICK_HALF   (CLICK_HALF),
        .CLICK_LEN    (CLICK_LEN),
        .SUCCESS_HALF (SUCCESS_HALF),
        .SUCCESS_LEN  (SUCCESS_LEN),
        .FAIL_HALF    (FAIL_HALF),
        .FAIL_LEN     (FAIL_LEN)
    ) u_buzzer_driver (
        .clk        (clk),
        .rst        (rst),
        .tone_req   (tone_req),
        .tone_ready (tone_ready),
        .buzzer     (buzzer)
    );

endmodule

`default_nettype wire

//--- testbench/code_lock_chk.sv
`timescale 1ns/10ps
`default_nettype none

module code_lock_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  buzzer,
    input logic                  tone_ready,
    input tone_pkg::tone_req_t   tone_req,
    input lock_pkg::key_event_t  key_event,
    input lock_pkg::lock_state_t status,
    input lock_pkg::display_t    display
);

    // an accepted tone starts high and keeps the driver busy
    buzzer_starts_on_accept: assert property (
        @(posedge clk) disable iff (rst)
        (tone_req.valid && tone_ready) |=> (buzzer && !tone_ready))
        else $error("buzzer did not start on the cycle after a tone was accepted");

    key_event_single_cycle: assert property (
        @(posedge clk) disable iff (rst) key_event.valid |=> !key_event.valid)
        else $error("key event valid for two cycles in a row");

    // lockout may only end once the countdown shows 00
    lockout_held_until_zero: assert property (
        @(posedge clk) disable iff (rst)
        (status == lock_pkg::ST_LOCKOUT && !(display.mid == 4'd0 && display.lo == 4'd0))
        |=> status == lock_pkg::ST_LOCKOUT)
        else $error("lockout left before the countdown reached 00");

endmodule

bind code_lock_top code_lock_chk u_code_lock_chk (
    .clk        (clk),
    .rst        (rst),
    .buzzer     (buzzer),
    .tone_ready (tone_ready),
    .tone_req   (tone_req),
    .key_event  (key_event),
    .status     (status),
    .display    (display)
);

`default_nettype wire

//--- testbench/code_lock_tb.sv
`timescale 1ns/10ps
`default_nettype none

module code_lock_tb;

    localparam int          SECOND_CYCLES   = 20;
    localparam int          MAX_TRIES       = 3;
    localparam int          LOCKOUT_SECONDS = 12;
    localparam logic [11:0] DEFAULT_CODE    = 12'h246;
    localparam int          CLICK_HALF      = 2;
    localparam int          N_RANDOM        = 80;
    localparam int          N_PRESSES       = N_RANDOM + 60;
    localparam int          LOCKOUT_CYC     = (LOCKOUT_SECONDS + 2) * SECOND_CYCLES;
    // a press is 6 cycles, random keys may lock out a few times
    localparam int          CYCLE_LIMIT     = N_PRESSES * 6 + 8 * LOCKOUT_CYC + 200;

    localparam logic [15:0] ENTER_KEYS = 16'h0001;
    localparam logic [15:0] SET_KEYS   = 16'h0010;
    localparam logic [15:0] CLEAR_KEYS = 16'h0100;

    localparam lock_pkg::display_t BLANK_DISP = {lock_pkg::GLYPH_BLANK,
        lock_pkg::GLYPH_BLANK, lock_pkg::GLYPH_BLANK};
    localparam lock_pkg::display_t DASH_DISP = {lock_pkg::GLYPH_DASH,
        lock_pkg::GLYPH_DASH, lock_pkg::GLYPH_DASH};
    localparam lock_pkg::display_t PASS_DISP = {lock_pkg::GLYPH_A,
        lock_pkg::GLYPH_S, lock_pkg::GLYPH_S};
    localparam lock_pkg::display_t LOCK_DISP = {lock_pkg::GLYPH_BLANK,
        4'(LOCKOUT_SECONDS / 10), 4'(LOCKOUT_SECONDS % 10)};
    localparam lock_pkg::display_t ZERO_DISP = {lock_pkg::GLYPH_BLANK, 4'd0, 4'd0};

    logic                  clk;
    logic                  rst;
    logic [15:0]           keys;
    lock_pkg::display_t    display;
    lock_pkg::lock_state_t status;
    logic [2:0]            tries;
    logic                  buzzer;

    int seed   = 32'h5147_ad0b;
    int cycles = 0;

    // lock model
    lock_pkg::lock_state_t m_st;
    lock_pkg::display_t    m_disp;
    lock_pkg::display_t    m_code;
    int                    m_tries;
    int                    m_cnt;  // digits entered

    code_lock_top #(
        .SECOND_CYCLES   (SECOND_CYCLES),
        .MAX_TRIES       (MAX_TRIES),
        .LOCKOUT_SECONDS (LOCKOUT_SECONDS),
        .DEFAULT_CODE    (DEFAULT_CODE),
        .CLICK_HALF      (CLICK_HALF),
        .CLICK_LEN       (8),
        .SUCCESS_HALF    (1),
        .SUCCESS_LEN     (12),
        .FAIL_HALF       (3),
        .FAIL_LEN        (18)
    ) u_code_lock_top (
        .clk     (clk),
        .rst     (rst),
        .keys    (keys),
        .display (display),
        .status  (status),
        .tries   (tries),
        .buzzer  (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
            fail_run("timeout, the run did not finish within the cycle limit");
    end

    task automatic check_display(input string name, input lock_pkg::display_t exp,
                                 input lock_pkg::display_t act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input lock_pkg::lock_state_t exp,
                                input lock_pkg::lock_state_t act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %s actual %s", name, exp.name(),
                               act.name()));
    endtask

    task automatic check_tries(input string name, input logic [2:0] exp,
                               input logic [2:0] act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            fail_run($sformatf("error %s: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("error %s: expected %b actual %b", name, exp, act));
    endtask

    task automatic check_state(input string name);
        check_display(name, m_disp, display);
        check_status(name, m_st, status);
        check_tries(name, 3'(m_tries), tries);
    endtask

    // key lines by bit number, only a single active line is a key
    function automatic logic decode_keys(input logic [15:0] p,
                                         output lock_pkg::key_code_t k);
        int b;
        b = 0;
        k = lock_pkg::KEY_ENTER;
        if ($countones(p) != 1)
            return 1'b0;
        for (int i = 0; i < 16; i++)
            if (p[i])
                b = i;
        case (b)
            0:  k = lock_pkg::KEY_ENTER;
            3:  k = lock_pkg::KEY_0;
            4:  k = lock_pkg::KEY_SET;
            5:  k = lock_pkg::KEY_3;
            6:  k = lock_pkg::KEY_2;
            7:  k = lock_pkg::KEY_1;
            8:  k = lock_pkg::KEY_CLEAR;
            9:  k = lock_pkg::KEY_6;
            10: k = lock_pkg::KEY_5;
            11: k = lock_pkg::KEY_4;
            12: k = lock_pkg::KEY_CANCEL;
            13: k = lock_pkg::KEY_9;
            15: k = lock_pkg::KEY_7;
            default: return 1'b0;  // lines 1, 2, 14 not wired
        endcase
        return 1'b1;
    endfunction

    function automatic logic [15:0] digit_keys(input lock_pkg::glyph_t d);
        case (d)
            4'd0: return 16'h0008;
            4'd1: return 16'h0080;
            4'd2: return 16'h0040;
            4'd3: return 16'h0020;
            4'd4: return 16'h0800;
            4'd5: return 16'h0400;
            4'd6: return 16'h0200;
            4'd7: return 16'h8000;
            4'd9: return 16'h2000;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic model_key(input lock_pkg::key_code_t k);
        case (m_st)
            lock_pkg::ST_ENTRY, lock_pkg::ST_SET: begin
                if (k <= lock_pkg::KEY_9) begin
                    if (m_cnt < 3) begin
                        m_disp = {m_disp.mid, m_disp.lo, lock_pkg::glyph_t'(k)};
                        m_cnt++;
                    end
                end else if (k == lock_pkg::KEY_ENTER && m_cnt == 3) begin
                    m_cnt = 0;
                    if (m_st == lock_pkg::ST_SET) begin
                        m_code = m_disp;
                        m_st   = lock_pkg::ST_ENTRY;
                        m_disp = BLANK_DISP;
                    end else if (m_disp == m_code) begin
                        m_st   = lock_pkg::ST_OPEN;
                        m_disp = PASS_DISP;
                    end else begin
                        m_tries++;
                        m_disp = BLANK_DISP;
                        if (m_tries == MAX_TRIES) begin
                            m_st   = lock_pkg::ST_LOCKOUT;
                            m_disp = LOCK_DISP;
                        end
                    end
                end else if (k == lock_pkg::KEY_CANCEL) begin
                    m_disp = BLANK_DISP;
                    m_cnt  = 0;
                end else if (k == lock_pkg::KEY_CLEAR) begin
                    if (m_st == lock_pkg::ST_ENTRY)
                        m_tries = 0;
                    m_st   = lock_pkg::ST_ENTRY;
                    m_disp = BLANK_DISP;
                    m_cnt  = 0;
                end
            end
            lock_pkg::ST_OPEN: begin
                if (k == lock_pkg::KEY_SET) begin
                    m_st   = lock_pkg::ST_SET;
                    m_disp = DASH_DISP;
                    m_cnt  = 0;
                end else if (k == lock_pkg::KEY_CLEAR) begin
                    m_st   = lock_pkg::ST_ENTRY;
                    m_disp = BLANK_DISP;
                    m_cnt  = 0;
                end
            end
            default: ;  // locked out
        endcase
    endtask

    // follows the countdown while random keys are thrown at the lock
    task automatic watch_lockout();
        lock_pkg::display_t exp_disp;
        int secs;
        int n;
        int last_step;
        exp_disp  = LOCK_DISP;
        secs      = LOCKOUT_SECONDS;
        n         = 0;
        last_step = -3;  // lockout began three edges before the press check
        while (status == lock_pkg::ST_LOCKOUT) begin
            @(posedge clk);
            if (secs == 0)
                keys <= '0;  // quiet before the unlock
            else if (n % 3 == 0)
                keys <= 16'($random(seed));
            n++;
            @(negedge clk);
            if (status == lock_pkg::ST_LOCKOUT) begin
                check_tries("tries during lockout", 3'(MAX_TRIES), tries);
                if (display != exp_disp) begin
                    secs--;
                    exp_disp = {lock_pkg::GLYPH_BLANK, 4'(secs / 10), 4'(secs % 10)};
                    check_display("lockout countdown", exp_disp, display);
                    check_count("lockout second length", SECOND_CYCLES, n - last_step);
                    last_step = n;
                end
            end
        end
        check_display("lockout last value", ZERO_DISP, exp_disp);
        check_count("lockout last second", SECOND_CYCLES, n - last_step);
        m_st    = lock_pkg::ST_ENTRY;
        m_disp  = BLANK_DISP;
        m_tries = 0;
        m_cnt   = 0;
        check_state("after lockout");
    endtask

    // 3 cycles held, 3 released, then compare with the model
    task automatic press(input logic [15:0] pattern, input string name);
        lock_pkg::key_code_t k;
        @(posedge clk);
        keys <= pattern;
        repeat (3) @(posedge clk);
        keys <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (decode_keys(pattern, k))
            model_key(k);
        check_state(name);
        if (m_st == lock_pkg::ST_LOCKOUT)
            watch_lockout();
    endtask

    task automatic enter_code(input lock_pkg::display_t c, input string name);
        press(digit_keys(c.hi), name);
        press(digit_keys(c.mid), name);
        press(digit_keys(c.lo), name);
        press(ENTER_KEYS, name);
    endtask

    task automatic random_code(output lock_pkg::display_t c);
        logic [3:0] d [3];
        for (int i = 0; i < 3; i++) begin
            d[i] = 4'({$random(seed)} % 9);
            if (d[i] == 4'd8)
                d[i] = 4'd9;  // no key for 8
        end
        c = {d[0], d[1], d[2]};
    endtask

    task automatic random_press();
        logic [31:0] r;
        logic [15:0] pat;
        r = $random(seed);
        if (r[3:0] < 4'd11)
            pat = 16'd1 << r[7:4];
        else
            pat = r[23:8];  // mostly multi-key patterns
        press(pat, "random keys");
    endtask

    task automatic measure_click();
        int n;
        @(posedge clk);
        keys <= digit_keys(4'd1);
        n = 0;
        while (buzzer !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 10)
                fail_run("buzzer did not rise after a digit press");
        end
        n = 0;
        while (buzzer === 1'b1) begin
            @(negedge clk);
            n++;
        end
        check_count("click half period", CLICK_HALF, n);
        @(posedge clk);
        keys <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        model_key(lock_pkg::KEY_1);
        check_state("click digit");
    endtask

    initial begin
        lock_pkg::display_t old_code;
        lock_pkg::display_t new_code;
        lock_pkg::display_t wrong;
        keys    = '0;
        rst     = 1'b1;
        m_st    = lock_pkg::ST_ENTRY;
        m_disp  = BLANK_DISP;
        m_code  = DEFAULT_CODE;
        m_tries = 0;
        m_cnt   = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_state("after reset");
        check_level("buzzer after reset", 1'b0, buzzer);
        measure_click();
        press(CLEAR_KEYS, "clear entry");

        enter_code(DEFAULT_CODE, "default code");
        check_status("default code opens", lock_pkg::ST_OPEN, status);
        check_display("pass pattern", PASS_DISP, display);
        press(CLEAR_KEYS, "relock from open");

        repeat (MAX_TRIES) begin  // last one locks out
            random_code(wrong);
            if (wrong == m_code)
                wrong.lo = (wrong.lo == 4'd0) ? 4'd1 : 4'd0;
            enter_code(wrong, "wrong code");
        end

        old_code = m_code;
        enter_code(old_code, "open before set");
        press(SET_KEYS, "set shows dashes");
        check_display("set dashes", DASH_DISP, display);
        do
            random_code(new_code);
        while (new_code == old_code);
        enter_code(new_code, "store new code");
        enter_code(old_code, "old code fails");
        check_tries("old code fails", 3'd1, tries);
        press(CLEAR_KEYS, "clear zeroes tries");
        enter_code(new_code, "new code opens");
        check_status("new code opens", lock_pkg::ST_OPEN, status);
        press(CLEAR_KEYS, "relock after new code");

        repeat (N_RANDOM) random_press();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/lock_pkg.sv
rtl/tone_pkg.sv
rtl/keypad_decoder.sv
rtl/lock_controller.sv
rtl/buzzer_driver.sv
rtl/code_lock_top.sv
testbench/code_lock_chk.sv
testbench/code_lock_tb.sv

//--- run.sh
#!/bin/sh
# builds the code lock testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module code_lock_tb -f tb.f -o code_lock_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/code_lock_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi
exit 0
